// File: source/csr_pkg.sv
`default_nettype none

package csr_pkg;

	// --------------------
	// Bus widths
	// --------------------
	localparam int WB_ADR_W = 32;
	localparam int DATA_W = 32;
	// CSR word address, Wishbone bits 15:2
	localparam int CSR_A_W = 14;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W = 10;

	// --------------------
	// Register map
	// --------------------
	localparam logic [CSR_BANK_W-1:0] BANK_SYSCTL = 4'd1;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN = 10'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT = 10'd1;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IRQ_EN = 10'd2;
	localparam logic [CSR_REG_W-1:0] REG_SYSTEM_ID = 10'd3;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CTRL = 10'd4;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CMP = 10'd5;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CNT = 10'd6;
	// Timer control bits
	localparam int TIMER_EN_BIT = 0;
	localparam int TIMER_AR_BIT = 1;
	// ASCII "MONE"
	localparam logic [DATA_W-1:0] SYSTEM_ID = 32'h4D4F4E45;

	// GPIO counts
	localparam int N_GPIO_IN = 3;
	localparam int N_GPIO_OUT = 2;

	// --------------------
	// Reset timing
	// --------------------
	localparam int RST_DEBOUNCE_CYCLES = 64;
	localparam int FLASH_RST_CYCLES = 16;
	localparam int RST_CNT_W = $clog2(RST_DEBOUNCE_CYCLES + 1);
	localparam int FLASH_CNT_W = $clog2(FLASH_RST_CYCLES + 1);
	localparam logic [RST_CNT_W-1:0] RST_CNT_LOAD = RST_CNT_W'(RST_DEBOUNCE_CYCLES);
	localparam logic [FLASH_CNT_W-1:0] FLASH_CNT_DONE = FLASH_CNT_W'(FLASH_RST_CYCLES);

	// Bridge FSM encoding
	localparam int BRG_ST_W = 3;
	localparam logic [BRG_ST_W-1:0] BRG_IDLE = 3'd0;
	localparam logic [BRG_ST_W-1:0] BRG_ADDR = 3'd1;
	localparam logic [BRG_ST_W-1:0] BRG_DATA = 3'd2;
	localparam logic [BRG_ST_W-1:0] BRG_ACK = 3'd3;
	localparam logic [BRG_ST_W-1:0] BRG_RECOVER = 3'd4;

endpackage

`default_nettype wire

// File: source/csr_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface csr_bus_if;

	// Master side, driven by the bridge
	logic [csr_pkg::CSR_A_W-1:0] csr_a;
	logic csr_we;
	logic [csr_pkg::DATA_W-1:0] csr_dw;

	// One read-data word per slave, ORed in the bridge
	logic [csr_pkg::DATA_W-1:0] dr_sysctl;
	logic [csr_pkg::DATA_W-1:0] dr_timer;

	// --------------------
	modport bridge (
		output csr_a, csr_we, csr_dw,
		input  dr_sysctl, dr_timer
	);

	modport sysctl (
		input  csr_a, csr_we, csr_dw,
		output dr_sysctl
	);

	modport timer (
		input  csr_a, csr_we, csr_dw,
		output dr_timer
	);

endinterface

`default_nettype wire

// File: source/reset_seq.sv
`timescale 1ns/1ns
`default_nettype none

module reset_seq (
	input  wire                          sys_clk,
	input  wire                          trigger_reset,
	input  wire [csr_pkg::N_GPIO_IN-1:0] btn_i,
	input  wire                          hard_reset_i,
	output logic                         sys_rst_o,
	output wire                          flash_rst_n_o
);

	// Any reset source, before and after the register
	logic trig_d;
	logic trig_q;
	// Debounce hold
	logic [csr_pkg::RST_CNT_W-1:0] rst_cnt;
	// Flash release
	logic [csr_pkg::FLASH_CNT_W-1:0] flash_cnt;

	// External reset, three-button chord or software request
	assign trig_d = trigger_reset | (&btn_i) | hard_reset_i;

	always_ff @(posedge sys_clk) begin
		trig_q <= trig_d;
	end

	// --------------------
	// System reset debounce
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (trig_q) begin
			rst_cnt <= csr_pkg::RST_CNT_LOAD;
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - csr_pkg::RST_CNT_W'(1);
		end
		sys_rst_o <= (rst_cnt != '0);
	end

	// --------------------
	// Flash reset release
	// --------------------
	// Cleared one edge early so flash is already in reset with the trigger
	always_ff @(posedge sys_clk) begin
		if (trig_d | trig_q) begin
			flash_cnt <= '0;
		end else if (!flash_rst_n_o) begin
			flash_cnt <= flash_cnt + csr_pkg::FLASH_CNT_W'(1);
		end
	end

	assign flash_rst_n_o = (flash_cnt == csr_pkg::FLASH_CNT_DONE);

	// Flash held in reset for the whole trigger
	a_flash_held: assert property (@(posedge sys_clk) trig_q |-> !flash_rst_n_o);
	// Flash is out of reset before the system starts fetching
	a_flash_first: assert property (@(posedge sys_clk) $fell(sys_rst_o) |-> flash_rst_n_o);

endmodule

`default_nettype wire

// File: source/wb_csr_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module wb_csr_bridge (
	input  wire                          sys_clk,
	input  wire                          sys_rst_i,
	input  wire [csr_pkg::WB_ADR_W-1:0]  wb_adr_i,
	input  wire [csr_pkg::DATA_W-1:0]    wb_dat_i,
	output logic [csr_pkg::DATA_W-1:0]   wb_dat_o,
	input  wire                          wb_we_i,
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	output logic                         wb_ack_o,
	csr_bus_if.bridge                    csr
);

	logic [csr_pkg::BRG_ST_W-1:0] state;
	// New access seen while idle
	logic wb_req;

	assign wb_req = wb_cyc_i & wb_stb_i & (state == csr_pkg::BRG_IDLE);

	// --------------------
	// Access sequencing
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= csr_pkg::BRG_IDLE;
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
		end else begin
			// Both strobes are single-cycle pulses
			wb_ack_o <= 1'b0;
			csr.csr_we <= 1'b0;
			case (state)
				csr_pkg::BRG_IDLE: begin
					if (wb_req) begin
						state <= csr_pkg::BRG_ADDR;
						csr.csr_we <= wb_we_i;
					end
				end
				// Slaves sample address and write here
				csr_pkg::BRG_ADDR: begin
					state <= csr_pkg::BRG_DATA;
				end
				// Registered slave data now valid
				csr_pkg::BRG_DATA: begin
					state <= csr_pkg::BRG_ACK;
					wb_ack_o <= 1'b1;
				end
				csr_pkg::BRG_ACK: begin
					state <= csr_pkg::BRG_RECOVER;
				end
				// Master still drops stb here
				default: begin
					state <= csr_pkg::BRG_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// Address and data latches
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (wb_req) begin
			csr.csr_a <= wb_adr_i[csr_pkg::CSR_A_W+1:2];
			csr.csr_dw <= wb_dat_i;
		end
		// Unaddressed slaves return zero so an OR is enough
		if (state == csr_pkg::BRG_DATA) begin
			wb_dat_o <= csr.dr_sysctl | csr.dr_timer;
		end
	end

	// No back-to-back acks or CSR writes
	a_ack_pulse: assert property (@(posedge sys_clk) wb_ack_o |=> !wb_ack_o);
	a_we_pulse: assert property (@(posedge sys_clk) csr.csr_we |=> !csr.csr_we);

endmodule

`default_nettype wire

// File: source/sysctl_gpio.sv
`timescale 1ns/1ns
`default_nettype none

module sysctl_gpio (
	input  wire                           sys_clk,
	input  wire                           sys_rst_i,
	input  wire [csr_pkg::N_GPIO_IN-1:0]  btn_i,
	output logic [csr_pkg::N_GPIO_OUT-1:0] led_o,
	output logic                          gpio_irq_o,
	output logic                          hard_reset_o,
	csr_bus_if.sysctl                     csr
);

	// Button synchronizer and edge history
	logic [csr_pkg::N_GPIO_IN-1:0] btn_meta;
	logic [csr_pkg::N_GPIO_IN-1:0] btn_sync;
	logic [csr_pkg::N_GPIO_IN-1:0] btn_prev;
	// Input-change interrupt mask
	logic [csr_pkg::N_GPIO_IN-1:0] irq_en;
	// CSR decode
	logic bank_sel;
	logic [csr_pkg::CSR_REG_W-1:0] reg_idx;
	logic wr_en;

	assign bank_sel = (csr.csr_a[csr_pkg::CSR_A_W-1 -: csr_pkg::CSR_BANK_W] ==
		csr_pkg::BANK_SYSCTL);
	assign reg_idx = csr.csr_a[csr_pkg::CSR_REG_W-1:0];
	assign wr_en = csr.csr_we & bank_sel;

	// --------------------
	// Button inputs
	// --------------------
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	// --------------------
	// Control registers
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= '0;
			irq_en <= '0;
			gpio_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;
		end else begin
			// Either edge of an enabled button
			gpio_irq_o <= |((btn_sync ^ btn_prev) & irq_en);
			// Any write to the ID word requests a hard reset
			hard_reset_o <= wr_en & (reg_idx == csr_pkg::REG_SYSTEM_ID);
			if (wr_en) begin
				case (reg_idx)
					csr_pkg::REG_GPIO_OUT: led_o <= csr.csr_dw[csr_pkg::N_GPIO_OUT-1:0];
					csr_pkg::REG_GPIO_IRQ_EN: irq_en <= csr.csr_dw[csr_pkg::N_GPIO_IN-1:0];
					default: begin
					end
				endcase
			end
		end
	end

	// --------------------
	// Read data
	// --------------------
	always_ff @(posedge sys_clk) begin
		csr.dr_sysctl <= '0;
		if (bank_sel) begin
			case (reg_idx)
				csr_pkg::REG_GPIO_IN: csr.dr_sysctl <=
					{{(csr_pkg::DATA_W-csr_pkg::N_GPIO_IN){1'b0}}, btn_sync};
				csr_pkg::REG_GPIO_OUT: csr.dr_sysctl <=
					{{(csr_pkg::DATA_W-csr_pkg::N_GPIO_OUT){1'b0}}, led_o};
				csr_pkg::REG_GPIO_IRQ_EN: csr.dr_sysctl <=
					{{(csr_pkg::DATA_W-csr_pkg::N_GPIO_IN){1'b0}}, irq_en};
				csr_pkg::REG_SYSTEM_ID: csr.dr_sysctl <= csr_pkg::SYSTEM_ID;
				// timer words come from the other slave
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/sys_timer.sv
`timescale 1ns/1ns
`default_nettype none

module sys_timer (
	input  wire       sys_clk,
	input  wire       sys_rst_i,
	output logic      timer_irq_o,
	csr_bus_if.timer  csr
);

	// Control bits
	logic en_q;
	logic ar_q;
	// Compare and running count
	logic [csr_pkg::DATA_W-1:0] cmp_q;
	logic [csr_pkg::DATA_W-1:0] cnt_q;
	// CSR decode
	logic bank_sel;
	logic [csr_pkg::CSR_REG_W-1:0] reg_idx;
	logic wr_en;
	// Control word as read back
	logic [csr_pkg::DATA_W-1:0] ctrl_word;

	assign bank_sel = (csr.csr_a[csr_pkg::CSR_A_W-1 -: csr_pkg::CSR_BANK_W] ==
		csr_pkg::BANK_SYSCTL);
	assign reg_idx = csr.csr_a[csr_pkg::CSR_REG_W-1:0];
	assign wr_en = csr.csr_we & bank_sel;

	always_comb begin
		ctrl_word = '0;
		ctrl_word[csr_pkg::TIMER_EN_BIT] = en_q;
		ctrl_word[csr_pkg::TIMER_AR_BIT] = ar_q;
	end

	// --------------------
	// Counter
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en_q <= 1'b0;
			ar_q <= 1'b0;
			cmp_q <= '0;
			cnt_q <= '0;
			timer_irq_o <= 1'b0;
		end else begin
			timer_irq_o <= 1'b0;
			if (en_q) begin
				if (cnt_q == cmp_q) begin
					// Match wraps the count, one-shot stops
					cnt_q <= '0;
					timer_irq_o <= 1'b1;
					en_q <= ar_q;
				end else begin
					cnt_q <= cnt_q + csr_pkg::DATA_W'(1);
				end
			end
			// Bus writes override the counter update
			if (wr_en) begin
				case (csr.csr_a[csr_pkg::CSR_REG_W-1:0])
					csr_pkg::REG_TIMER_CTRL: begin
						en_q <= csr.csr_dw[csr_pkg::TIMER_EN_BIT];
						ar_q <= csr.csr_dw[csr_pkg::TIMER_AR_BIT];
					end
					csr_pkg::REG_TIMER_CMP: cmp_q <= csr.csr_dw;
					csr_pkg::REG_TIMER_CNT: cnt_q <= csr.csr_dw;
					default: begin
					end
				endcase
			end
		end
	end

	// Read data, zero when not addressed
	always_ff @(posedge sys_clk) begin
		csr.dr_timer <= '0;
		if (bank_sel) begin
			case (reg_idx)
				csr_pkg::REG_TIMER_CTRL: csr.dr_timer <= ctrl_word;
				csr_pkg::REG_TIMER_CMP: csr.dr_timer <= cmp_q;
				csr_pkg::REG_TIMER_CNT: csr.dr_timer <= cnt_q;
				default: begin
				end
			endcase
		end
	end

	// Interrupt only from a running timer
	a_irq_enabled: assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		timer_irq_o |-> $past(en_q));

endmodule

`default_nettype wire

// File: source/csr_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module csr_subsys_top (
	input  wire                           sys_clk,
	input  wire                           trigger_reset,
	// Wishbone slave
	input  wire [csr_pkg::WB_ADR_W-1:0]   wb_adr_i,
	input  wire [csr_pkg::DATA_W-1:0]     wb_dat_i,
	output wire [csr_pkg::DATA_W-1:0]     wb_dat_o,
	input  wire                           wb_we_i,
	input  wire                           wb_cyc_i,
	input  wire                           wb_stb_i,
	output wire                           wb_ack_o,
	// GPIO
	input  wire [csr_pkg::N_GPIO_IN-1:0]  btn_i,
	output wire [csr_pkg::N_GPIO_OUT-1:0] led_o,
	// Interrupts
	output wire                           gpio_irq_o,
	output wire                           timer_irq_o,
	// Resets
	output wire                           periph_rst_n_o,
	output wire                           flash_rst_n_o
);

	wire sys_rst;
	wire hard_reset;

	// CSR bus shared by the bridge and both slaves
	csr_bus_if u_csr_bus ();

	// --------------------
	// Reset generation
	// --------------------
	reset_seq u_reset_seq (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.btn_i         (btn_i),
		.hard_reset_i  (hard_reset),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	// Single peripheral reset output
	assign periph_rst_n_o = ~sys_rst;

	// --------------------
	// Bus and slaves
	// --------------------
	wb_csr_bridge u_wb_csr_bridge (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_we_i   (wb_we_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_ack_o  (wb_ack_o),
		.csr       (u_csr_bus.bridge)
	);

	sysctl_gpio u_sysctl_gpio (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.btn_i        (btn_i),
		.led_o        (led_o),
		.gpio_irq_o   (gpio_irq_o),
		.hard_reset_o (hard_reset),
		.csr          (u_csr_bus.sysctl)
	);

	sys_timer u_sys_timer (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.timer_irq_o (timer_irq_o),
		.csr         (u_csr_bus.timer)
	);

endmodule

`default_nettype wire

// File: include/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Expected register state, updated on each bus write
bit [csr_pkg::N_GPIO_OUT-1:0] exp_led;
bit [csr_pkg::N_GPIO_IN-1:0] exp_irq_en;
bit [csr_pkg::DATA_W-1:0] exp_tmr_cmp;
bit exp_tmr_en;
bit exp_tmr_ar;

// State after a system reset
function automatic void reset_expected();
	exp_led = '0;
	exp_irq_en = '0;
	exp_tmr_cmp = '0;
	exp_tmr_en = 1'b0;
	exp_tmr_ar = 1'b0;
endfunction

// --------------------
// Address split, bank in bits 15:12, index in 11:2
// --------------------
function automatic bit in_sysctl_bank(input bit [csr_pkg::WB_ADR_W-1:0] adr);
	return adr[csr_pkg::CSR_A_W+1 -: csr_pkg::CSR_BANK_W] == csr_pkg::BANK_SYSCTL;
endfunction

function automatic bit [csr_pkg::CSR_REG_W-1:0] reg_index(
	input bit [csr_pkg::WB_ADR_W-1:0] adr);
	return adr[csr_pkg::CSR_REG_W+1:2];
endfunction

function automatic void record_write(input bit [csr_pkg::WB_ADR_W-1:0] adr,
	input bit [csr_pkg::DATA_W-1:0] dat);
	if (!in_sysctl_bank(adr)) return;
	case (reg_index(adr))
		csr_pkg::REG_GPIO_OUT: exp_led = dat[csr_pkg::N_GPIO_OUT-1:0];
		csr_pkg::REG_GPIO_IRQ_EN: exp_irq_en = dat[csr_pkg::N_GPIO_IN-1:0];
		csr_pkg::REG_TIMER_CTRL: begin
			exp_tmr_en = dat[csr_pkg::TIMER_EN_BIT];
			exp_tmr_ar = dat[csr_pkg::TIMER_AR_BIT];
		end
		csr_pkg::REG_TIMER_CMP: exp_tmr_cmp = dat;
		default: ;
	endcase
endfunction

// Match seen, one-shot drops its enable
function automatic void timer_fired();
	if (!exp_tmr_ar) exp_tmr_en = 1'b0;
endfunction

// Count register is free running and is not modelled
function automatic bit [csr_pkg::DATA_W-1:0] expected_read(
	input bit [csr_pkg::WB_ADR_W-1:0] adr,
	input bit [csr_pkg::N_GPIO_IN-1:0] btn);
	bit [csr_pkg::DATA_W-1:0] dat;
	dat = '0;
	if (!in_sysctl_bank(adr)) return dat;
	case (reg_index(adr))
		csr_pkg::REG_GPIO_IN: dat[csr_pkg::N_GPIO_IN-1:0] = btn;
		csr_pkg::REG_GPIO_OUT: dat[csr_pkg::N_GPIO_OUT-1:0] = exp_led;
		csr_pkg::REG_GPIO_IRQ_EN: dat[csr_pkg::N_GPIO_IN-1:0] = exp_irq_en;
		csr_pkg::REG_SYSTEM_ID: dat = csr_pkg::SYSTEM_ID;
		csr_pkg::REG_TIMER_CTRL: begin
			dat[csr_pkg::TIMER_EN_BIT] = exp_tmr_en;
			dat[csr_pkg::TIMER_AR_BIT] = exp_tmr_ar;
		end
		csr_pkg::REG_TIMER_CMP: dat = exp_tmr_cmp;
		default: ;
	endcase
	return dat;
endfunction

`endif

// File: tb/tb_csr_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_csr_subsys;

	// Wait limits in clock cycles
	localparam int ACK_LIMIT = 16;
	localparam int RST_LIMIT = 4 * csr_pkg::RST_DEBOUNCE_CYCLES;
	localparam int IRQ_LIMIT = 20;
	localparam int TIMER_LIMIT = 80;
	// Signals the wait loop can watch
	localparam int SIG_ACK = 0;
	localparam int SIG_FLASH = 1;
	localparam int SIG_PERIPH = 2;
	localparam int SIG_GPIO_IRQ = 3;
	localparam int SIG_TIMER_IRQ = 4;
	localparam logic [csr_pkg::N_GPIO_IN-1:0] ALL_BTN = '1;
	localparam logic [csr_pkg::DATA_W-1:0] CTRL_EN = 32'd1 << csr_pkg::TIMER_EN_BIT;
	localparam logic [csr_pkg::DATA_W-1:0] CTRL_AR = 32'd1 << csr_pkg::TIMER_AR_BIT;

	logic sys_clk;
	logic trigger_reset;
	logic [csr_pkg::WB_ADR_W-1:0] wb_adr_i;
	logic [csr_pkg::DATA_W-1:0] wb_dat_i;
	wire [csr_pkg::DATA_W-1:0] wb_dat_o;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	wire wb_ack_o;
	logic [csr_pkg::N_GPIO_IN-1:0] btn_i;
	wire [csr_pkg::N_GPIO_OUT-1:0] led_o;
	wire gpio_irq_o;
	wire timer_irq_o;
	wire periph_rst_n_o;
	wire flash_rst_n_o;

	// Register model
	`include "csr_ref_model.svh"

	csr_subsys_top u_csr_subsys_top (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_dat_o       (wb_dat_o),
		.wb_we_i        (wb_we_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_ack_o       (wb_ack_o),
		.btn_i          (btn_i),
		.led_o          (led_o),
		.gpio_irq_o     (gpio_irq_o),
		.timer_irq_o    (timer_irq_o),
		.periph_rst_n_o (periph_rst_n_o),
		.flash_rst_n_o  (flash_rst_n_o)
	);

	// 4 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// --------------------
	// Helpers
	// --------------------
	// Next drive point, 1 ns after the edge
	task automatic step();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic fail_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		fail_run();
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			SIG_FLASH: return flash_rst_n_o;
			SIG_PERIPH: return periph_rst_n_o;
			SIG_GPIO_IRQ: return gpio_irq_o;
			SIG_TIMER_IRQ: return timer_irq_o;
			default: return wb_ack_o;
		endcase
	endfunction

	// Poll one output until it reaches a level
	task automatic wait_for(input int sel, input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (probe(sel) !== level) begin
			if (n >= limit) report_timeout(what);
			step();
			n++;
		end
	endtask

	// Bank 1 word address
	function automatic logic [31:0] reg_adr(input logic [csr_pkg::CSR_REG_W-1:0] idx);
		return {16'h0000, csr_pkg::BANK_SYSCTL, idx, 2'b00};
	endfunction

	// One button to flip, never leading to the reset chord
	function automatic logic [csr_pkg::N_GPIO_IN-1:0] toggle_mask(
		input logic [csr_pkg::N_GPIO_IN-1:0] cur);
		int start;
		int k;
		logic [csr_pkg::N_GPIO_IN-1:0] tgl;
		start = int'($urandom % csr_pkg::N_GPIO_IN);
		tgl = '0;
		for (k = 0; k < csr_pkg::N_GPIO_IN; k++) begin
			tgl = csr_pkg::N_GPIO_IN'(1) << ((start + k) % csr_pkg::N_GPIO_IN);
			if ((cur ^ tgl) != ALL_BTN) break;
		end
		return tgl;
	endfunction

	// --------------------
	// Wishbone master
	// --------------------
	task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
		wb_adr_i = adr;
		wb_dat_i = dat;
		wb_we_i = 1'b1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wait_for(SIG_ACK, 1'b1, ACK_LIMIT, "Wishbone write ack");
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		// stb stays low for a cycle after ack
		step();
		record_write(adr, dat);
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
		wb_adr_i = adr;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wait_for(SIG_ACK, 1'b1, ACK_LIMIT, "Wishbone read ack");
		dat = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		step();
	endtask

	task automatic read_check(input logic [31:0] adr, input string what);
		logic [31:0] got;
		wb_read(adr, got);
		check_eq(got, expected_read(adr, btn_i), what);
	endtask

	task automatic count_gpio_irq(input int cycles, output int pulses);
		int k;
		pulses = 0;
		for (k = 0; k < cycles; k++) begin
			step();
			if (gpio_irq_o) pulses++;
		end
	endtask

	// Nonzero state so a reset is visible
	task automatic load_nonzero();
		wb_write(reg_adr(csr_pkg::REG_GPIO_OUT), $urandom | 32'h1);
		wb_write(reg_adr(csr_pkg::REG_GPIO_IRQ_EN), $urandom | 32'h1);
		wb_write(reg_adr(csr_pkg::REG_TIMER_CMP), $urandom | 32'h1);
		wb_write(reg_adr(csr_pkg::REG_TIMER_CTRL), CTRL_AR);
	endtask

	task automatic wait_reset_cycle(input string what);
		wait_for(SIG_PERIPH, 1'b0, RST_LIMIT, {what, " reset entry"});
		wait_for(SIG_PERIPH, 1'b1, RST_LIMIT, {what, " reset release"});
		check_eq(32'(flash_rst_n_o), 32'd1, {what, " flash reset released"});
		reset_expected();
	endtask

	task automatic check_cleared(input string what);
		read_check(reg_adr(csr_pkg::REG_GPIO_OUT), {what, " LED register"});
		read_check(reg_adr(csr_pkg::REG_GPIO_IRQ_EN), {what, " IRQ mask"});
		read_check(reg_adr(csr_pkg::REG_TIMER_CTRL), {what, " timer control"});
		read_check(reg_adr(csr_pkg::REG_TIMER_CMP), {what, " timer compare"});
		read_check(reg_adr(csr_pkg::REG_TIMER_CNT), {what, " timer count"});
		check_eq(32'(led_o), 32'd0, {what, " led_o"});
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		logic [csr_pkg::DATA_W-1:0] dat;
		logic [csr_pkg::WB_ADR_W-1:0] adr;
		logic [csr_pkg::N_GPIO_IN-1:0] tgl;
		logic [csr_pkg::CSR_REG_W-1:0] idx;
		int pulses;
		int i;
		void'($urandom(31));
		reset_expected();
		trigger_reset = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		btn_i = '0;
		repeat (3) @(posedge sys_clk);
		#1;
		trigger_reset = 1'b0;

		// 1: release order, flash before peripherals
		check_eq(32'(periph_rst_n_o), 32'd0, "periph_rst_n_o in reset");
		check_eq(32'(flash_rst_n_o), 32'd0, "flash_rst_n_o in reset");
		wait_for(SIG_FLASH, 1'b1, RST_LIMIT, "flash reset release");
		check_eq(32'(periph_rst_n_o), 32'd0, "periph_rst_n_o at flash release");
		wait_for(SIG_PERIPH, 1'b1, RST_LIMIT, "peripheral reset release");
		check_eq(32'(led_o), 32'd0, "led_o after reset");
		check_eq(32'(gpio_irq_o), 32'd0, "gpio_irq_o after reset");
		check_eq(32'(timer_irq_o), 32'd0, "timer_irq_o after reset");

		// 2: random register read-back
		for (i = 0; i < 24; i++) begin
			case ($urandom % 4)
				0: idx = csr_pkg::REG_GPIO_OUT;
				1: idx = csr_pkg::REG_GPIO_IRQ_EN;
				2: idx = csr_pkg::REG_TIMER_CMP;
				default: idx = csr_pkg::REG_TIMER_CTRL;
			endcase
			dat = $urandom;
			// Timer kept stopped, count must not move
			if (idx == csr_pkg::REG_TIMER_CTRL) dat[csr_pkg::TIMER_EN_BIT] = 1'b0;
			wb_write(reg_adr(idx), dat);
			read_check(reg_adr(idx), $sformatf("register %0d read-back", idx));
			check_eq(32'(led_o), 32'(exp_led), "led_o");
		end
		read_check(reg_adr(csr_pkg::REG_SYSTEM_ID), "system ID");
		for (i = 0; i < 8; i++) begin
			adr = $urandom;
			if (adr[csr_pkg::CSR_A_W+1 -: csr_pkg::CSR_BANK_W] == csr_pkg::BANK_SYSCTL)
				adr[13] = ~adr[13];
			wb_read(adr, dat);
			check_eq(dat, 32'd0, "read outside the bank");
			idx = csr_pkg::CSR_REG_W'(7 + ($urandom % 1017));
			wb_read(reg_adr(idx), dat);
			check_eq(dat, 32'd0, "read of unused register index");
		end

		// 3: buttons and input-change interrupt
		for (i = 0; i < 6; i++) begin
			btn_i = csr_pkg::N_GPIO_IN'($urandom % ALL_BTN);
			repeat (4) step();
			read_check(reg_adr(csr_pkg::REG_GPIO_IN), "button inputs");
			tgl = toggle_mask(btn_i);
			wb_write(reg_adr(csr_pkg::REG_GPIO_IRQ_EN), 32'(tgl));
			btn_i = btn_i ^ tgl;
			wait_for(SIG_GPIO_IRQ, 1'b1, IRQ_LIMIT, "masked-in button interrupt");
			count_gpio_irq(8, pulses);
			check_eq(pulses, 32'd0, "cycles of gpio_irq_o after the pulse");
			// Other buttons enabled, this one masked out
			tgl = toggle_mask(btn_i);
			wb_write(reg_adr(csr_pkg::REG_GPIO_IRQ_EN), 32'(ALL_BTN & ~tgl));
			btn_i = btn_i ^ tgl;
			count_gpio_irq(10, pulses);
			check_eq(pulses, 32'd0, "gpio_irq_o pulses from masked button");
		end

		// 4: timer, one-shot then auto-restart
		wb_write(reg_adr(csr_pkg::REG_TIMER_CTRL), 32'd0);
		wb_write(reg_adr(csr_pkg::REG_TIMER_CNT), 32'd0);
		wb_write(reg_adr(csr_pkg::REG_TIMER_CMP), 32'(4 + ($urandom % 13)));
		wb_write(reg_adr(csr_pkg::REG_TIMER_CTRL), CTRL_EN);
		wait_for(SIG_TIMER_IRQ, 1'b1, TIMER_LIMIT, "one-shot timer interrupt");
		timer_fired();
		step();
		check_eq(32'(timer_irq_o), 32'd0, "timer_irq_o pulse width");
		read_check(reg_adr(csr_pkg::REG_TIMER_CTRL), "one-shot timer control");
		wb_write(reg_adr(csr_pkg::REG_TIMER_CNT), 32'd0);
		wb_write(reg_adr(csr_pkg::REG_TIMER_CTRL), CTRL_EN | CTRL_AR);
		for (i = 0; i < 2; i++) begin
			wait_for(SIG_TIMER_IRQ, 1'b1, TIMER_LIMIT, "auto-restart timer interrupt");
			step();
		end
		timer_fired();
		read_check(reg_adr(csr_pkg::REG_TIMER_CTRL), "auto-restart timer control");
		wb_write(reg_adr(csr_pkg::REG_TIMER_CTRL), 32'd0);

		// 5: software hard reset, then button chord
		load_nonzero();
		wb_write(reg_adr(csr_pkg::REG_SYSTEM_ID), $urandom);
		wait_reset_cycle("hard reset");
		check_cleared("after hard reset");
		load_nonzero();
		btn_i = ALL_BTN;
		repeat (3) step();
		btn_i = '0;
		wait_reset_cycle("button chord");
		check_cleared("after button chord");

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: csr_subsys.f
+incdir+include
source/csr_pkg.sv
source/csr_bus_if.sv
source/reset_seq.sv
source/wb_csr_bridge.sv
source/sysctl_gpio.sv
source/sys_timer.sv
source/csr_subsys_top.sv
tb/tb_csr_subsys.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f csr_subsys.f --top-module tb_csr_subsys -o tb_csr_subsys
./obj_dir/tb_csr_subsys > sim.log 2>&1 || true
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
